//--- sift_pixel_pkg.sv
`default_nettype none

package sift_pixel_pkg;

    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0]      pix_t;
    typedef logic signed [PIX_W:0] diff_t;  // pixel difference with sign

    // |a - b|, always fits back into a pixel
    function automatic pix_t pix_absdiff(input pix_t a, input pix_t b);
        diff_t d;
        d = diff_t'({1'b0, a}) - diff_t'({1'b0, b});
        return (d < 0) ? pix_t'(-d) : pix_t'(d);
    endfunction

endpackage

`default_nettype wire

//--- sift_ctrl_pkg.sv
`default_nettype none

package sift_ctrl_pkg;

    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_BLUR   = 3'd1,
        PH_DETECT = 3'd2,
        PH_MATCH  = 3'd3,
        PH_DONE   = 3'd4
    } phase_t;

    localparam int DRAIN_CYCLES = 3;  // match pipeline depth

endpackage

`default_nettype wire

//--- sync_ram.sv
`timescale 1ns/1ns
`default_nettype none

module sync_ram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- scan_counter.sv
`timescale 1ns/1ns
`default_nettype none

module scan_counter #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clear,
    input  logic                       run,
    input  logic [$clog2(ROWS*COLS):0] limit,
    output logic [$clog2(ROWS*COLS):0] idx,
    output logic                       sweep_end
);

    import sift_ctrl_pkg::*;

    localparam int CNT_W   = $clog2(ROWS*COLS) + 1;
    localparam int DRAIN_W = $clog2(DRAIN_CYCLES + 1);

    logic [DRAIN_W-1:0] drain;
    logic               at_end;

    assign at_end    = (idx >= limit);
    assign sweep_end = run && at_end && (drain == DRAIN_W'(DRAIN_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx   <= '0;
            drain <= '0;
        end else if (clear) begin
            idx   <= '0;
            drain <= '0;
        end else if (run && !at_end) begin
            idx <= idx + CNT_W'(1);
        end else if (run && (drain != DRAIN_W'(DRAIN_CYCLES))) begin
            drain <= drain + DRAIN_W'(1);  // pipelines empty meanwhile
        end
    end

endmodule

`default_nettype wire

//--- phase_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module phase_fsm #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       sweep_end,
    input  logic [$clog2(ROWS*COLS):0] kpt_count,
    output sift_ctrl_pkg::phase_t      phase,
    output logic                       sweep_clear,
    output logic                       run,
    output logic [$clog2(ROWS*COLS):0] sweep_limit,
    output logic                       done
);

    import sift_ctrl_pkg::*;

    localparam int CNT_W = $clog2(ROWS*COLS) + 1;
    localparam int KPTS  = ROWS * COLS;

    phase_t nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            phase <= nxt;
        end
    end

    always_comb begin
        case (phase)
            PH_IDLE, PH_DONE: nxt = start ? PH_BLUR : phase;
            PH_BLUR:          nxt = sweep_end ? PH_DETECT : PH_BLUR;
            PH_DETECT:        nxt = sweep_end ? PH_MATCH : PH_DETECT;
            PH_MATCH:         nxt = sweep_end ? PH_DONE : PH_MATCH;
            default:          nxt = PH_IDLE;
        endcase
    end

    // counter restarts in step with the phase register
    assign sweep_clear = (nxt != phase);
    assign run         = (phase == PH_BLUR) || (phase == PH_DETECT) || (phase == PH_MATCH);
    assign done        = (phase == PH_DONE);

    always_comb begin
        case (phase)
            PH_BLUR, PH_DETECT: sweep_limit = CNT_W'(KPTS);
            PH_MATCH:           sweep_limit = kpt_count;
            default:            sweep_limit = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- row_blur.sv
`timescale 1ns/1ns
`default_nettype none

module row_blur #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  sift_ctrl_pkg::phase_t                phase,
    input  logic [$clog2(ROWS*COLS):0]           idx,
    input  logic [COLS*sift_pixel_pkg::PIX_W-1:0] img_row,
    output logic                                 blur_we,
    output logic [$clog2(ROWS)-1:0]              blur_waddr,
    output logic [COLS*sift_pixel_pkg::PIX_W-1:0] blur_row
);

    import sift_ctrl_pkg::*;
    import sift_pixel_pkg::*;

    localparam int IDX_W  = $clog2(ROWS*COLS);
    localparam int ROW_AW = $clog2(ROWS);
    localparam int COL_AW = $clog2(COLS);

    logic              vld_q;
    logic [ROW_AW-1:0] row_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= (phase == PH_BLUR) && !idx[IDX_W] && (idx[COL_AW-1:0] == '0);
        end
    end

    always_ff @(posedge clk) begin
        row_q <= idx[IDX_W-1:COL_AW];
    end

    assign blur_we    = vld_q;
    assign blur_waddr = row_q;

    for (genvar c = 0; c < COLS; c++) begin : g_col
        pix_t             lft;
        pix_t             rgt;
        logic [PIX_W+1:0] sum;
        if (c == 0) begin : g_ledge
            assign lft = '0;  // zero past the left edge
        end else begin : g_lin
            assign lft = img_row[(c-1)*PIX_W +: PIX_W];
        end
        if (c == COLS - 1) begin : g_redge
            assign rgt = '0;
        end else begin : g_rin
            assign rgt = img_row[(c+1)*PIX_W +: PIX_W];
        end
        assign sum = {2'b00, lft} + {1'b0, img_row[c*PIX_W +: PIX_W], 1'b0} + {2'b00, rgt};
        assign blur_row[c*PIX_W +: PIX_W] = sum[PIX_W+1:2];
    end

endmodule

`default_nettype wire

//--- keypoint_detect.sv
`timescale 1ns/1ns
`default_nettype none

module keypoint_detect #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  sift_ctrl_pkg::phase_t                phase,
    input  logic [$clog2(ROWS*COLS):0]           idx,
    input  logic [COLS*sift_pixel_pkg::PIX_W-1:0] img_row,
    input  logic [COLS*sift_pixel_pkg::PIX_W-1:0] blur_row,
    input  logic                                 filter_on,
    input  sift_pixel_pkg::pix_t                 threshold,
    output logic                                 kpt_we,
    output logic [$clog2(ROWS*COLS)-1:0]         kpt_waddr,
    output logic [$clog2(ROWS*COLS)-1:0]         kpt_wdata,
    output logic [$clog2(ROWS*COLS):0]           kpt_count
);

    import sift_ctrl_pkg::*;
    import sift_pixel_pkg::*;

    localparam int IDX_W  = $clog2(ROWS*COLS);
    localparam int COL_AW = $clog2(COLS);

    logic             vld_q;
    logic [IDX_W-1:0] pos_q;  // {row, col}, lines up with read data
    pix_t             img_pix;
    pix_t             blr_pix;
    pix_t             diff;
    logic             hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= (phase == PH_DETECT) && !idx[IDX_W];
        end
    end

    always_ff @(posedge clk) begin
        pos_q <= idx[IDX_W-1:0];
    end

    assign img_pix = img_row[pos_q[COL_AW-1:0]*PIX_W +: PIX_W];
    assign blr_pix = blur_row[pos_q[COL_AW-1:0]*PIX_W +: PIX_W];
    assign diff    = pix_absdiff(img_pix, blr_pix);
    assign hit     = filter_on ? (diff > threshold) : (diff != '0);

    assign kpt_we    = vld_q && hit;
    assign kpt_waddr = kpt_count[IDX_W-1:0];
    assign kpt_wdata = pos_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kpt_count <= '0;
        end else if (phase == PH_BLUR) begin
            kpt_count <= '0;  // fresh run
        end else if (kpt_we) begin
            kpt_count <= kpt_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- keypoint_match.sv
`timescale 1ns/1ns
`default_nettype none

module keypoint_match #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  sift_ctrl_pkg::phase_t                          phase,
    input  logic [$clog2(ROWS*COLS):0]                     idx,
    output logic [$clog2(ROWS*COLS)-1:0]                   kpt_raddr,
    input  logic [$clog2(ROWS*COLS)-1:0]                   kpt_rdata,
    output logic [$clog2(ROWS*COLS)-1:0]                   tgt_raddr,
    input  sift_pixel_pkg::pix_t                           tgt_rdata,
    output logic [$clog2(ROWS)-1:0]                        blur_raddr,
    input  logic [COLS*sift_pixel_pkg::PIX_W-1:0]          blur_row,
    output logic                                           m_we,
    output logic [$clog2(ROWS*COLS)-1:0]                   m_waddr,
    output logic [$clog2(ROWS*COLS)+sift_pixel_pkg::PIX_W-1:0] m_wdata
);

    import sift_ctrl_pkg::*;
    import sift_pixel_pkg::*;

    localparam int IDX_W  = $clog2(ROWS*COLS);
    localparam int COL_AW = $clog2(COLS);

    logic             s1_live;
    logic [IDX_W:0]   s1_k;
    logic             s2_ok;
    logic             s2_valid;
    logic [IDX_W-1:0] s2_k;
    logic [IDX_W-1:0] s2_rec;  // {row, col} of keypoint
    pix_t             s2_tgt;
    pix_t             blur_pix;

    // stage 1 reads keypoint and target entry k
    assign kpt_raddr = idx[IDX_W-1:0];
    assign tgt_raddr = idx[IDX_W-1:0];

    // k was a real index only if the counter moved past it
    assign s2_ok = s1_live && (phase == PH_MATCH) && (idx != s1_k);

    assign blur_raddr = (phase == PH_MATCH) ? kpt_rdata[IDX_W-1:COL_AW]
                                            : idx[IDX_W-1:COL_AW];
    assign blur_pix   = blur_row[s2_rec[COL_AW-1:0]*PIX_W +: PIX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_live  <= 1'b0;
            s2_valid <= 1'b0;
            m_we     <= 1'b0;
        end else begin
            s1_live  <= (phase == PH_MATCH);
            s2_valid <= s2_ok;
            m_we     <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_k    <= idx;
        s2_k    <= s1_k[IDX_W-1:0];
        s2_rec  <= kpt_rdata;
        s2_tgt  <= tgt_rdata;
        m_waddr <= s2_k;
        m_wdata <= {s2_rec, pix_absdiff(blur_pix, s2_tgt)};
    end

endmodule

`default_nettype wire

//--- sift_top.sv
`timescale 1ns/1ns
`default_nettype none

module sift_top #(
    parameter int ROWS = 8,
    parameter int COLS = 8
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           start,
    input  logic                                           filter_on,
    input  sift_pixel_pkg::pix_t                           threshold,
    input  logic                                           img_we,
    input  logic [$clog2(ROWS)-1:0]                        img_addr_in,
    input  logic [COLS*sift_pixel_pkg::PIX_W-1:0]          img_din,
    input  logic                                           target_we,
    input  logic [$clog2(ROWS*COLS)-1:0]                   target_addr_in,
    input  sift_pixel_pkg::pix_t                           target_din,
    input  logic [$clog2(ROWS*COLS)-1:0]                   matched_addr,
    output logic [$clog2(ROWS*COLS)+sift_pixel_pkg::PIX_W-1:0] matched_dout,
    output logic                                           done,
    output logic [$clog2(ROWS*COLS):0]                     kpt_count
);

    import sift_ctrl_pkg::*;
    import sift_pixel_pkg::*;

    localparam int IDX_W  = $clog2(ROWS*COLS);
    localparam int ROW_AW = $clog2(ROWS);
    localparam int COL_AW = $clog2(COLS);
    localparam int KPTS   = ROWS * COLS;

    typedef logic [COLS*PIX_W-1:0]   row_t;
    typedef logic [IDX_W-1:0]        kpt_t;   // {row, col}
    typedef logic [IDX_W+PIX_W-1:0]  mrec_t;  // {row, col, diff}

    phase_t      phase;
    logic        sweep_clear, run, sweep_end;
    logic [IDX_W:0] sweep_limit, idx;
    row_t        img_row, blur_wrow, blur_row;
    logic        blur_we, kpt_we, m_we;
    logic [ROW_AW-1:0] blur_waddr, blur_raddr;
    kpt_t        kpt_wdata, kpt_rdata;
    logic [IDX_W-1:0] kpt_waddr, kpt_raddr, tgt_raddr, m_waddr;
    pix_t        tgt_rdata;
    mrec_t       m_wdata;

    phase_fsm #(.ROWS(ROWS), .COLS(COLS)) u_fsm (
        .clk(clk), .rst_n(rst_n), .start(start), .sweep_end(sweep_end),
        .kpt_count(kpt_count), .phase(phase), .sweep_clear(sweep_clear), .run(run),
        .sweep_limit(sweep_limit), .done(done)
    );

    scan_counter #(.ROWS(ROWS), .COLS(COLS)) u_scan (
        .clk(clk), .rst_n(rst_n), .clear(sweep_clear), .run(run),
        .limit(sweep_limit), .idx(idx), .sweep_end(sweep_end)
    );

    row_blur #(.ROWS(ROWS), .COLS(COLS)) u_blur (
        .clk(clk), .rst_n(rst_n), .phase(phase), .idx(idx), .img_row(img_row),
        .blur_we(blur_we), .blur_waddr(blur_waddr), .blur_row(blur_wrow)
    );

    keypoint_detect #(.ROWS(ROWS), .COLS(COLS)) u_detect (
        .clk(clk), .rst_n(rst_n), .phase(phase), .idx(idx), .img_row(img_row),
        .blur_row(blur_row), .filter_on(filter_on), .threshold(threshold),
        .kpt_we(kpt_we), .kpt_waddr(kpt_waddr), .kpt_wdata(kpt_wdata),
        .kpt_count(kpt_count)
    );

    keypoint_match #(.ROWS(ROWS), .COLS(COLS)) u_match (
        .clk(clk), .rst_n(rst_n), .phase(phase), .idx(idx),
        .kpt_raddr(kpt_raddr), .kpt_rdata(kpt_rdata),
        .tgt_raddr(tgt_raddr), .tgt_rdata(tgt_rdata),
        .blur_raddr(blur_raddr), .blur_row(blur_row),
        .m_we(m_we), .m_waddr(m_waddr), .m_wdata(m_wdata)
    );

    sync_ram #(.word_t(row_t), .DEPTH(ROWS)) u_img_ram (
        .clk(clk), .we(img_we), .waddr(img_addr_in), .wdata(img_din),
        .raddr(idx[IDX_W-1:COL_AW]), .rdata(img_row)
    );

    sync_ram #(.word_t(row_t), .DEPTH(ROWS)) u_blur_ram (
        .clk(clk), .we(blur_we), .waddr(blur_waddr), .wdata(blur_wrow),
        .raddr(blur_raddr), .rdata(blur_row)
    );

    sync_ram #(.word_t(kpt_t), .DEPTH(KPTS)) u_kpt_ram (
        .clk(clk), .we(kpt_we), .waddr(kpt_waddr), .wdata(kpt_wdata),
        .raddr(kpt_raddr), .rdata(kpt_rdata)
    );

    sync_ram #(.word_t(pix_t), .DEPTH(KPTS)) u_tgt_ram (
        .clk(clk), .we(target_we), .waddr(target_addr_in), .wdata(target_din),
        .raddr(tgt_raddr), .rdata(tgt_rdata)
    );

    sync_ram #(.word_t(mrec_t), .DEPTH(KPTS)) u_matched_ram (
        .clk(clk), .we(m_we), .waddr(m_waddr), .wdata(m_wdata),
        .raddr(matched_addr), .rdata(matched_dout)
    );

endmodule

`default_nettype wire

//--- sift_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module sift_asserts #(
    parameter int ROWS     = 8,
    parameter int COLS     = 8,
    parameter bit FSM_SIDE = 1'b0
) (
    input logic                       clk,
    input logic                       rst_n,
    input sift_ctrl_pkg::phase_t      phase,
    input logic                       done,
    input logic                       kpt_we,
    input logic [$clog2(ROWS*COLS):0] kpt_count
);

    import sift_ctrl_pkg::*;

    localparam int KPTS = ROWS * COLS;

    if (FSM_SIDE) begin : g_fsm
        // done phase is reached only from the end of match
        a_done_phase: assert property (@(posedge clk) disable iff (!rst_n)
            done |-> (phase == PH_DONE) && ($past(done) || ($past(phase) == PH_MATCH)))
            else $error("done is high outside a done phase entered from match");

        a_kpt_cap: assert property (@(posedge clk) disable iff (!rst_n)
            kpt_count <= KPTS)
            else $error("kpt_count is above the keypoint capacity");
    end else begin : g_detect
        a_kpt_we_phase: assert property (@(posedge clk) disable iff (!rst_n)
            kpt_we |-> (phase == PH_DETECT))
            else $error("keypoint write outside the detect phase");
    end

endmodule

// sequencer has no keypoint write of its own
bind phase_fsm sift_asserts #(
    .ROWS(ROWS), .COLS(COLS), .FSM_SIDE(1'b1)
) u_fsm_asserts (
    .clk(clk), .rst_n(rst_n), .phase(phase), .done(done),
    .kpt_we(1'b0), .kpt_count(kpt_count)
);

bind keypoint_detect sift_asserts #(
    .ROWS(ROWS), .COLS(COLS), .FSM_SIDE(1'b0)
) u_detect_asserts (
    .clk(clk), .rst_n(rst_n), .phase(phase), .done(1'b0),
    .kpt_we(kpt_we), .kpt_count(kpt_count)
);

`default_nettype wire

//--- tb_sift.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sift;

    import sift_pixel_pkg::*;

    localparam int ROWS    = 8;
    localparam int COLS    = 8;
    localparam int IDX_W   = $clog2(ROWS*COLS);
    localparam int ROW_AW  = $clog2(ROWS);
    localparam int COL_AW  = $clog2(COLS);
    localparam int KPTS    = ROWS * COLS;
    localparam int RUN_MAX = 1000;  // cycles for one full run

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   filter_on;
    pix_t                   threshold;
    logic                   img_we;
    logic [ROW_AW-1:0]      img_addr_in;
    logic [COLS*PIX_W-1:0]  img_din;
    logic                   target_we;
    logic [IDX_W-1:0]       target_addr_in;
    pix_t                   target_din;
    logic [IDX_W-1:0]       matched_addr;
    logic [IDX_W+PIX_W-1:0] matched_dout;
    logic                   done;
    logic [IDX_W:0]         kpt_count;

    int img [ROWS][COLS];  // model copy of loaded image
    int tgt [KPTS];
    int kpts [$];          // r*COLS + c, raster order
    int n_checks;
    int n_errors;
    int seed_val;

    sift_top #(.ROWS(ROWS), .COLS(COLS)) dut (
        .clk(clk), .rst_n(rst_n), .start(start), .filter_on(filter_on),
        .threshold(threshold), .img_we(img_we), .img_addr_in(img_addr_in),
        .img_din(img_din), .target_we(target_we), .target_addr_in(target_addr_in),
        .target_din(target_din), .matched_addr(matched_addr),
        .matched_dout(matched_dout), .done(done), .kpt_count(kpt_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // 1-2-1 with zero past the row edges
    function automatic int blur_at(input int r, input int c);
        int lft;
        int rgt;
        lft = (c > 0) ? img[r][c-1] : 0;
        rgt = (c < COLS - 1) ? img[r][c+1] : 0;
        return (lft + 2 * img[r][c] + rgt) / 4;
    endfunction

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    task automatic find_keypoints(input logic use_thr, input int thr);
        int d;
        kpts.delete();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                d = abs_diff(img[r][c], blur_at(r, c));
                if (use_thr ? (d > thr) : (d != 0)) begin
                    kpts.push_back(r * COLS + c);
                end
            end
        end
    endtask

    task automatic load_data(input logic random_img);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                img[r][c] = random_img ? int'($urandom % 256) : 0;
                img_din[c*PIX_W +: PIX_W] = pix_t'(img[r][c]);
            end
            img_we      = 1'b1;
            img_addr_in = ROW_AW'(r);
            step();
        end
        img_we = 1'b0;
        for (int k = 0; k < KPTS; k++) begin
            tgt[k]         = int'($urandom % 256);
            target_we      = 1'b1;
            target_addr_in = IDX_W'(k);
            target_din     = pix_t'(tgt[k]);
            step();
        end
        target_we = 1'b0;
    endtask

    task automatic run_to_done();
        int cycles;
        start = 1'b1;
        step();
        start = 1'b0;
        step();
        check_val("kpt_count at blur", 0, kpt_count);  // cleared on entry
        cycles = 0;
        while (!done && cycles < RUN_MAX) begin
            step();
            cycles++;
        end
        if (!done) begin
            n_errors++;
            $display("timeout: done did not rise within %0d cycles of start", RUN_MAX);
        end
    endtask

    task automatic check_results();
        int r;
        int c;
        check_val("kpt_count", kpts.size(), kpt_count);
        for (int k = 0; k < kpts.size(); k++) begin
            r = kpts[k] / COLS;
            c = kpts[k] % COLS;
            matched_addr = IDX_W'(k);
            step();  // read data one cycle later
            check_val($sformatf("matched[%0d].row", k), r,
                      matched_dout[IDX_W+PIX_W-1:COL_AW+PIX_W]);
            check_val($sformatf("matched[%0d].col", k), c,
                      matched_dout[COL_AW+PIX_W-1:PIX_W]);
            check_val($sformatf("matched[%0d].diff", k),
                      abs_diff(blur_at(r, c), tgt[k]), matched_dout[PIX_W-1:0]);
        end
    endtask

    task automatic test_reset_state();
        check_val("done", 0, done);
        check_val("kpt_count", 0, kpt_count);
    endtask

    task automatic test_any_diff();
        load_data(1'b1);
        filter_on = 1'b0;
        find_keypoints(1'b0, 0);
        run_to_done();
        check_results();
    endtask

    task automatic test_zero_image();
        load_data(1'b0);
        filter_on = 1'b0;
        find_keypoints(1'b0, 0);
        run_to_done();
        check_val("done", 1, done);
        check_results();
    endtask

    task automatic test_threshold(input int thr);
        load_data(1'b1);
        filter_on = 1'b1;
        threshold = pix_t'(thr);
        find_keypoints(1'b1, thr);
        run_to_done();
        check_results();
    endtask

    task automatic test_second_start();
        check_val("done before restart", 1, done);
        load_data(1'b1);
        filter_on = 1'b1;
        threshold = pix_t'(10);
        find_keypoints(1'b1, 10);
        run_to_done();
        check_results();
    endtask

    initial begin
        seed_val       = $urandom(32'h4549b634);
        n_checks       = 0;
        n_errors       = 0;
        rst_n          = 1'b0;
        start          = 1'b0;
        filter_on      = 1'b0;
        threshold      = '0;
        img_we         = 1'b0;
        img_addr_in    = '0;
        img_din        = '0;
        target_we      = 1'b0;
        target_addr_in = '0;
        target_din     = '0;
        matched_addr   = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        test_reset_state();
        test_any_diff();
        test_zero_image();
        test_threshold(40);
        test_second_start();

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
sift_pixel_pkg.sv
sift_ctrl_pkg.sv
sync_ram.sv
scan_counter.sv
phase_fsm.sv
row_blur.sv
keypoint_detect.sv
keypoint_match.sv
sift_top.sv
sift_asserts.sv
tb_sift.sv
